// File: design/resolver_pkg.sv
package resolver_pkg;

    // One position or velocity sample from the converter
    typedef logic [15:0] resolver_value_t;

    // Contents of the converter fault register
    typedef logic [7:0] resolver_fault_t;

    // The raw serial word carries the value in the upper 16 bits and the faults in the lower 8
    typedef logic [23:0] resolver_word_t;

    // The read kind is also the A1:A0 address that selects the converter output
    typedef enum logic [1:0] {
        read_angle = 2'b00,
        read_speed = 2'b01
    } read_kind_t;

    typedef enum logic [2:0] {
        idle,
        sample_low,
        settle,
        shift,
        done
    } reader_state_t;

endpackage

// File: design/read_trigger_gen.sv
`timescale 1ns/10ps

module read_trigger_gen #(
    parameter int TRIGGER_PERIOD = 200,
    parameter int SPEED_RATIO = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    output logic angle_request,
    output logic speed_request
);

    localparam int PERIOD_WIDTH = (TRIGGER_PERIOD > 1) ? $clog2(TRIGGER_PERIOD) : 1;
    localparam int RATIO_WIDTH = (SPEED_RATIO > 1) ? $clog2(SPEED_RATIO) : 1;
    localparam logic [PERIOD_WIDTH-1:0] PERIOD_LAST = PERIOD_WIDTH'(TRIGGER_PERIOD - 1);
    localparam logic [RATIO_WIDTH-1:0] RATIO_LAST = RATIO_WIDTH'(SPEED_RATIO - 1);

    logic [PERIOD_WIDTH-1:0] period_count;
    logic [RATIO_WIDTH-1:0] ratio_count;

    always_ff @(posedge clock) begin
        if (!reset || !enable) begin
            // Dropping enable restarts both counters so the next run starts a full period out
            period_count <= '0;
            ratio_count <= '0;
            angle_request <= 1'b0;
            speed_request <= 1'b0;
        end else begin
            angle_request <= 1'b0;
            speed_request <= 1'b0;
            if (period_count == PERIOD_LAST) begin
                period_count <= '0;
                angle_request <= 1'b1;
                // The speed request lands on the same cycle as every SPEED_RATIO-th angle request
                if (ratio_count == RATIO_LAST) begin
                    ratio_count <= '0;
                    speed_request <= 1'b1;
                end else begin
                    ratio_count <= ratio_count + 1'b1;
                end
            end else begin
                period_count <= period_count + 1'b1;
            end
        end
    end

endmodule

// File: design/ad2s1210_reader.sv
`timescale 1ns/10ps

module ad2s1210_reader #(
    parameter int SCLK_HALF = 2,
    parameter int SAMPLE_CYCLES = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          angle_request,
    input  logic                          speed_request,
    input  logic                          sdo,
    output logic                          sample,
    output resolver_pkg::read_kind_t      addr,
    output logic                          ss,
    output logic                          sclk,
    output logic                          result_valid,
    output resolver_pkg::resolver_value_t result_value,
    output resolver_pkg::resolver_fault_t result_fault,
    output resolver_pkg::read_kind_t      result_kind
);

    localparam int WORD_BITS = $bits(resolver_pkg::resolver_word_t);
    localparam int FAULT_BITS = $bits(resolver_pkg::resolver_fault_t);
    localparam int COUNT_WIDTH = $clog2(WORD_BITS);
    localparam int TIMER_MAX = (SAMPLE_CYCLES > SCLK_HALF) ? SAMPLE_CYCLES : SCLK_HALF;
    localparam int TIMER_WIDTH = (TIMER_MAX > 1) ? $clog2(TIMER_MAX) : 1;
    localparam logic [TIMER_WIDTH-1:0] SAMPLE_LAST = TIMER_WIDTH'(SAMPLE_CYCLES - 1);
    localparam logic [TIMER_WIDTH-1:0] HALF_LAST = TIMER_WIDTH'(SCLK_HALF - 1);
    localparam logic [COUNT_WIDTH-1:0] BIT_LAST = COUNT_WIDTH'(WORD_BITS - 1);

    resolver_pkg::reader_state_t state;
    resolver_pkg::read_kind_t kind;
    resolver_pkg::resolver_word_t shift_word;
    logic angle_pending;
    logic speed_pending;
    logic [TIMER_WIDTH-1:0] timer;
    logic [COUNT_WIDTH-1:0] bit_count;
    logic half_done;
    logic capture;

    assign half_done = (timer == HALF_LAST);

    // A bit is taken at the end of each sclk high phase, which is before the
    // converter moves to the next bit on the falling edge. The first high phase
    // follows the fall of ss, where the MSB is already on sdo
    assign capture = (state == resolver_pkg::shift) && half_done && sclk;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= resolver_pkg::idle;
            kind <= resolver_pkg::read_angle;
            angle_pending <= 1'b0;
            speed_pending <= 1'b0;
            timer <= '0;
            bit_count <= '0;
            sample <= 1'b1;
            addr <= resolver_pkg::read_angle;
            ss <= 1'b1;
            sclk <= 1'b1;
            result_valid <= 1'b0;
        end else begin
            // Requests that arrive during a read wait here until the FSM is idle
            angle_pending <= angle_pending | angle_request;
            speed_pending <= speed_pending | speed_request;
            result_valid <= 1'b0;

            case (state)
                resolver_pkg::idle: begin
                    timer <= '0;
                    if (angle_pending || speed_pending) begin
                        sample <= 1'b0;
                        state <= resolver_pkg::sample_low;
                        // Angle reads take priority when both are waiting
                        if (angle_pending) begin
                            kind <= resolver_pkg::read_angle;
                            angle_pending <= angle_request;
                        end else begin
                            kind <= resolver_pkg::read_speed;
                            speed_pending <= speed_request;
                        end
                    end
                end
                resolver_pkg::sample_low: begin
                    if (timer == SAMPLE_LAST) begin
                        timer <= '0;
                        sample <= 1'b1;
                        addr <= kind;
                        state <= resolver_pkg::settle;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                resolver_pkg::settle: begin
                    if (half_done) begin
                        timer <= '0;
                        bit_count <= '0;
                        ss <= 1'b0;
                        state <= resolver_pkg::shift;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                resolver_pkg::shift: begin
                    if (half_done) begin
                        timer <= '0;
                        if (!sclk) begin
                            sclk <= 1'b1;
                        end else if (bit_count == BIT_LAST) begin
                            // Last bit taken, so sclk stays at its idle level
                            state <= resolver_pkg::done;
                        end else begin
                            sclk <= 1'b0;
                            bit_count <= bit_count + 1'b1;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                resolver_pkg::done: begin
                    ss <= 1'b1;
                    result_valid <= 1'b1;
                    state <= resolver_pkg::idle;
                end
                default: begin
                    state <= resolver_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            shift_word <= {shift_word[WORD_BITS-2:0], sdo};
        end
        if (state == resolver_pkg::done) begin
            result_value <= shift_word[WORD_BITS-1:FAULT_BITS];
            result_fault <= shift_word[FAULT_BITS-1:0];
            result_kind <= kind;
        end
    end

endmodule

// File: design/sample_router.sv
`timescale 1ns/10ps

module sample_router (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          result_valid,
    input  resolver_pkg::resolver_value_t result_value,
    input  resolver_pkg::resolver_fault_t result_fault,
    input  resolver_pkg::read_kind_t      result_kind,
    output logic                          angle_valid,
    output resolver_pkg::resolver_value_t angle_value,
    output resolver_pkg::resolver_fault_t angle_fault,
    output logic                          angle_overrun,
    input  logic                          angle_ready,
    output logic                          speed_valid,
    output resolver_pkg::resolver_value_t speed_value,
    output resolver_pkg::resolver_fault_t speed_fault,
    output logic                          speed_overrun,
    input  logic                          speed_ready
);

    logic angle_load;
    logic speed_load;

    assign angle_load = result_valid && (result_kind == resolver_pkg::read_angle);
    assign speed_load = result_valid && (result_kind == resolver_pkg::read_speed);

    // A new result replaces an item that was not taken, and the loss is recorded
    // in the sticky overrun flag of that stream
    always_ff @(posedge clock) begin
        if (!reset) begin
            angle_valid <= 1'b0;
            angle_overrun <= 1'b0;
            speed_valid <= 1'b0;
            speed_overrun <= 1'b0;
        end else begin
            if (angle_load) begin
                angle_valid <= 1'b1;
                if (angle_valid && !angle_ready) begin
                    angle_overrun <= 1'b1;
                end
            end else if (angle_ready) begin
                angle_valid <= 1'b0;
            end

            if (speed_load) begin
                speed_valid <= 1'b1;
                if (speed_valid && !speed_ready) begin
                    speed_overrun <= 1'b1;
                end
            end else if (speed_ready) begin
                speed_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (angle_load) begin
            angle_value <= result_value;
            angle_fault <= result_fault;
        end
        if (speed_load) begin
            speed_value <= result_value;
            speed_fault <= result_fault;
        end
    end

endmodule

// File: design/resolver_top.sv
`timescale 1ns/10ps

module resolver_top #(
    parameter int TRIGGER_PERIOD = 200,
    parameter int SPEED_RATIO = 4,
    parameter int SCLK_HALF = 2,
    parameter int SAMPLE_CYCLES = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          enable,
    input  logic                          sdo,
    output logic                          sample,
    output resolver_pkg::read_kind_t      addr,
    output logic                          ss,
    output logic                          sclk,
    output logic                          angle_valid,
    input  logic                          angle_ready,
    output resolver_pkg::resolver_value_t angle_value,
    output resolver_pkg::resolver_fault_t angle_fault,
    output logic                          angle_overrun,
    output logic                          speed_valid,
    input  logic                          speed_ready,
    output resolver_pkg::resolver_value_t speed_value,
    output resolver_pkg::resolver_fault_t speed_fault,
    output logic                          speed_overrun
);

    logic angle_request;
    logic speed_request;
    logic result_valid;
    resolver_pkg::resolver_value_t result_value;
    resolver_pkg::resolver_fault_t result_fault;
    resolver_pkg::read_kind_t result_kind;

    read_trigger_gen #(
        .TRIGGER_PERIOD(TRIGGER_PERIOD),
        .SPEED_RATIO(SPEED_RATIO)
    ) trigger_gen_i (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .angle_request(angle_request),
        .speed_request(speed_request)
    );

    // The converter cannot be stalled, so results flow to the router without a ready
    ad2s1210_reader #(
        .SCLK_HALF(SCLK_HALF),
        .SAMPLE_CYCLES(SAMPLE_CYCLES)
    ) reader_i (
        .clock(clock),
        .reset(reset),
        .angle_request(angle_request),
        .speed_request(speed_request),
        .sdo(sdo),
        .sample(sample),
        .addr(addr),
        .ss(ss),
        .sclk(sclk),
        .result_valid(result_valid),
        .result_value(result_value),
        .result_fault(result_fault),
        .result_kind(result_kind)
    );

    sample_router router_i (
        .clock(clock),
        .reset(reset),
        .result_valid(result_valid),
        .result_value(result_value),
        .result_fault(result_fault),
        .result_kind(result_kind),
        .angle_valid(angle_valid),
        .angle_value(angle_value),
        .angle_fault(angle_fault),
        .angle_overrun(angle_overrun),
        .angle_ready(angle_ready),
        .speed_valid(speed_valid),
        .speed_value(speed_value),
        .speed_fault(speed_fault),
        .speed_overrun(speed_overrun),
        .speed_ready(speed_ready)
    );

endmodule

// File: verif/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

    // Reset is active low and released on a rising edge
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b1;
    end

endmodule

// File: verif/ad2s1210_model.sv
`timescale 1ns/10ps

module ad2s1210_model (
    input  logic                         sample,
    input  resolver_pkg::read_kind_t     addr,
    input  logic                         ss,
    input  logic                         sclk,
    output logic                         sdo,
    output resolver_pkg::resolver_word_t read_word,
    output resolver_pkg::read_kind_t     read_kind,
    output int                           read_count,
    output int                           sample_count
);

    integer seed;
    logic [31:0] draw;
    resolver_pkg::resolver_word_t angle_word;
    resolver_pkg::resolver_word_t speed_word;
    resolver_pkg::resolver_word_t shift_word;
    logic ss_last;
    logic sclk_last;

    initial begin
        seed = 32'h45197198;
        angle_word = '0;
        speed_word = '0;
        shift_word = '0;
        read_word = '0;
        read_kind = resolver_pkg::read_angle;
        read_count = 0;
        sample_count = 0;
        ss_last = 1'b0;
        sclk_last = 1'b0;
    end

    // Both the position and the velocity registers are updated when sample falls
    always @(negedge sample) begin
        draw = $random(seed);
        angle_word = draw[23:0];
        draw = $random(seed);
        speed_word = draw[23:0];
        sample_count = sample_count + 1;
    end

    always @(ss or sclk) begin
        if (ss === 1'b0 && ss_last === 1'b1) begin
            // The address picks the word, and its MSB goes out right away
            shift_word = (addr == resolver_pkg::read_speed) ? speed_word : angle_word;
            read_word = shift_word;
            read_kind = addr;
            read_count = read_count + 1;
        end else if (ss === 1'b0 && sclk === 1'b0 && sclk_last === 1'b1) begin
            shift_word = {shift_word[22:0], 1'b0};
        end
        ss_last = ss;
        sclk_last = sclk;
    end

    assign sdo = shift_word[23];

endmodule

// File: verif/resolver_assertions.sv
`timescale 1ns/10ps

module resolver_assertions (
    input logic                          clock,
    input logic                          reset,
    input logic                          ss,
    input logic                          sclk,
    input resolver_pkg::read_kind_t      addr,
    input logic                          result_valid,
    input resolver_pkg::read_kind_t      result_kind,
    input logic                          angle_valid,
    input logic                          angle_ready,
    input resolver_pkg::resolver_value_t angle_value,
    input resolver_pkg::resolver_fault_t angle_fault,
    input logic                          speed_valid,
    input logic                          speed_ready,
    input resolver_pkg::resolver_value_t speed_value,
    input resolver_pkg::resolver_fault_t speed_fault
);

    int failure_count = 0;
    logic angle_hold;
    logic speed_hold;

    // A held item may only be replaced by a new result of its own kind
    assign angle_hold = angle_valid && !angle_ready &&
        !(result_valid && result_kind == resolver_pkg::read_angle);
    assign speed_hold = speed_valid && !speed_ready &&
        !(result_valid && result_kind == resolver_pkg::read_speed);

    sclk_in_frame: assert property (@(posedge clock) disable iff (!reset)
        sclk != $past(sclk) |-> !ss)
        else begin
            failure_count = failure_count + 1;
            $error("sclk toggled while ss was high");
        end

    addr_stable: assert property (@(posedge clock) disable iff (!reset)
        !ss |-> addr == $past(addr))
        else begin
            failure_count = failure_count + 1;
            $error("addr changed while ss was low");
        end

    angle_stable: assert property (@(posedge clock) disable iff (!reset)
        angle_hold |=> angle_valid && angle_value == $past(angle_value) &&
            angle_fault == $past(angle_fault))
        else begin
            failure_count = failure_count + 1;
            $error("angle item changed while waiting for ready");
        end

    speed_stable: assert property (@(posedge clock) disable iff (!reset)
        speed_hold |=> speed_valid && speed_value == $past(speed_value) &&
            speed_fault == $past(speed_fault))
        else begin
            failure_count = failure_count + 1;
            $error("speed item changed while waiting for ready");
        end

endmodule

bind resolver_top resolver_assertions assertions_i (
    .clock(clock),
    .reset(reset),
    .ss(ss),
    .sclk(sclk),
    .addr(addr),
    .result_valid(result_valid),
    .result_kind(result_kind),
    .angle_valid(angle_valid),
    .angle_ready(angle_ready),
    .angle_value(angle_value),
    .angle_fault(angle_fault),
    .speed_valid(speed_valid),
    .speed_ready(speed_ready),
    .speed_value(speed_value),
    .speed_fault(speed_fault)
);

// File: verif/resolver_tb.sv
`timescale 1ns/10ps

module resolver_tb;

    localparam int TRIGGER_PERIOD = 250;
    localparam int SPEED_RATIO = 4;
    localparam int SCLK_HALF = 2;
    localparam int SAMPLE_CYCLES = 4;
    localparam int ANGLE_READS = 2 * SPEED_RATIO;

    // Test lengths in trigger periods, which size the watchdog
    localparam int IDLE_PERIODS = 3;
    localparam int STREAM_PERIODS = ANGLE_READS + 3;
    localparam int HOLD_PERIODS = 5;
    localparam int STOP_PERIODS = SPEED_RATIO + 3;
    localparam int MARGIN_PERIODS = 6;
    localparam int WATCHDOG_CYCLES = TRIGGER_PERIOD *
        (IDLE_PERIODS + STREAM_PERIODS + HOLD_PERIODS + STOP_PERIODS + MARGIN_PERIODS);

    logic clock;
    logic reset;
    logic enable;
    logic sdo;
    logic sample;
    logic ss;
    logic sclk;
    resolver_pkg::read_kind_t addr;
    logic angle_valid;
    logic angle_ready;
    logic angle_overrun;
    resolver_pkg::resolver_value_t angle_value;
    resolver_pkg::resolver_fault_t angle_fault;
    logic speed_valid;
    logic speed_ready;
    logic speed_overrun;
    resolver_pkg::resolver_value_t speed_value;
    resolver_pkg::resolver_fault_t speed_fault;

    resolver_pkg::resolver_word_t read_word;
    resolver_pkg::read_kind_t read_kind;
    int read_count;
    int sample_count;

    resolver_pkg::resolver_word_t angle_words[$];
    resolver_pkg::resolver_word_t speed_words[$];
    int reads_seen = 0;
    int angle_transfers = 0;
    int speed_transfers = 0;
    bit angle_drop_older = 1'b0;
    int error_count = 0;
    int test_start_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int wait_cycles;
    int count_before;
    int samples_before;
    int assertion_failures;

    clock_gen #(.PERIOD(40), .RESET_CYCLES(2)) clock_gen_i (
        .clock(clock),
        .reset(reset)
    );

    resolver_top #(
        .TRIGGER_PERIOD(TRIGGER_PERIOD),
        .SPEED_RATIO(SPEED_RATIO),
        .SCLK_HALF(SCLK_HALF),
        .SAMPLE_CYCLES(SAMPLE_CYCLES)
    ) resolver_top_i (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .sdo(sdo),
        .sample(sample),
        .addr(addr),
        .ss(ss),
        .sclk(sclk),
        .angle_valid(angle_valid),
        .angle_ready(angle_ready),
        .angle_value(angle_value),
        .angle_fault(angle_fault),
        .angle_overrun(angle_overrun),
        .speed_valid(speed_valid),
        .speed_ready(speed_ready),
        .speed_value(speed_value),
        .speed_fault(speed_fault),
        .speed_overrun(speed_overrun)
    );

    ad2s1210_model model_i (
        .sample(sample),
        .addr(addr),
        .ss(ss),
        .sclk(sclk),
        .sdo(sdo),
        .read_word(read_word),
        .read_kind(read_kind),
        .read_count(read_count),
        .sample_count(sample_count)
    );

    // The converter word carries the value in its upper 16 bits and the fault byte below
    function automatic void expected_sample(input resolver_pkg::resolver_word_t word,
            output resolver_pkg::resolver_value_t value,
            output resolver_pkg::resolver_fault_t fault);
        value = word[23:8];
        fault = word[7:0];
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("error at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_transfer(input string name, ref resolver_pkg::resolver_word_t words[$],
            input bit drop_older, input resolver_pkg::resolver_value_t value,
            input resolver_pkg::resolver_fault_t fault);
        resolver_pkg::resolver_value_t exp_value;
        resolver_pkg::resolver_fault_t exp_fault;
        if (words.size() == 0) begin
            $display("%s transfer at %0d ns without any converter read behind it", name, $time);
            error_count = error_count + 1;
        end else begin
            // Under back-pressure only the newest read reaches the stream
            while (drop_older && words.size() > 1) begin
                void'(words.pop_front());
            end
            expected_sample(words.pop_front(), exp_value, exp_fault);
            check_value({name, "_value"}, int'(exp_value), int'(value));
            check_value({name, "_fault"}, int'(exp_fault), int'(fault));
        end
    endtask

    task automatic wait_read_done(input resolver_pkg::read_kind_t kind);
        bit found;
        found = 1'b0;
        while (!found) begin
            @(negedge clock);
            found = !ss && read_kind == kind;
        end
        while (!ss) begin
            @(negedge clock);
        end
        // Result pulse and router load follow the rise of ss
        repeat (3) @(negedge clock);
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        if (error_count == test_start_errors) begin
            $display("test %0d %s passed", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s failed with %0d errors", tests_run, name,
                error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    // Each word that goes out on sdo is recorded under its address
    always @(negedge clock) begin
        if (read_count != reads_seen) begin
            reads_seen = read_count;
            if (read_kind == resolver_pkg::read_speed) begin
                speed_words.push_back(read_word);
            end else begin
                angle_words.push_back(read_word);
            end
        end
    end

    always @(posedge clock) begin
        if (reset && angle_valid && angle_ready) begin
            check_transfer("angle", angle_words, angle_drop_older, angle_value, angle_fault);
            angle_transfers = angle_transfers + 1;
        end
        if (reset && speed_valid && speed_ready) begin
            check_transfer("speed", speed_words, 1'b0, speed_value, speed_fault);
            speed_transfers = speed_transfers + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        enable = 1'b0;
        angle_ready = 1'b1;
        speed_ready = 1'b1;
        while (!reset) begin
            @(negedge clock);
        end

        repeat (IDLE_PERIODS * TRIGGER_PERIOD) begin
            @(negedge clock);
            check_value("ss", 1, int'(ss));
            check_value("sclk", 1, int'(sclk));
            check_value("sample", 1, int'(sample));
            check_value("addr", 0, int'(addr));
            check_value("angle_valid", 0, int'(angle_valid));
            check_value("speed_valid", 0, int'(speed_valid));
            check_value("angle_overrun", 0, int'(angle_overrun));
            check_value("speed_overrun", 0, int'(speed_overrun));
        end
        check_value("read_count", 0, read_count);
        check_value("sample_count", 0, sample_count);
        finish_test("idle after reset");

        @(posedge clock);
        enable <= 1'b1;
        while (angle_transfers < ANGLE_READS) begin
            @(negedge clock);
        end
        finish_test("angle stream");

        // The speed read for the last angle period finishes after the angle transfer
        wait_cycles = 0;
        while (speed_transfers < angle_transfers / SPEED_RATIO && wait_cycles < TRIGGER_PERIOD) begin
            @(negedge clock);
            wait_cycles = wait_cycles + 1;
        end
        check_value("speed_transfers", angle_transfers / SPEED_RATIO, speed_transfers);
        finish_test("speed stream");

        @(posedge clock);
        angle_ready <= 1'b0;
        repeat (3) begin
            wait_read_done(resolver_pkg::read_angle);
            check_value("angle_valid", 1, int'(angle_valid));
        end
        check_value("angle_overrun", 1, int'(angle_overrun));
        angle_drop_older = 1'b1;
        count_before = angle_transfers;
        @(posedge clock);
        angle_ready <= 1'b1;
        while (angle_transfers == count_before) begin
            @(negedge clock);
        end
        angle_drop_older = 1'b0;
        check_value("angle words left", 0, angle_words.size());
        check_value("speed_overrun", 0, int'(speed_overrun));
        finish_test("angle back-pressure");

        // Drop enable in the middle of a speed read, after which nothing is pending
        while (ss || read_kind != resolver_pkg::read_speed) begin
            @(negedge clock);
        end
        @(posedge clock);
        enable <= 1'b0;
        speed_ready <= 1'b0;
        samples_before = sample_count;
        count_before = speed_transfers;
        // The last speed item waits against a low ready before it is taken
        repeat (TRIGGER_PERIOD) @(negedge clock);
        check_value("speed_valid", 1, int'(speed_valid));
        @(posedge clock);
        speed_ready <= 1'b1;
        repeat (TRIGGER_PERIOD) @(negedge clock);
        check_value("sample_count", samples_before, sample_count);
        check_value("speed_transfers", count_before + 1, speed_transfers);
        check_value("speed_overrun", 0, int'(speed_overrun));
        check_value("angle words left", 0, angle_words.size());
        check_value("speed words left", 0, speed_words.size());
        finish_test("stop after enable drop");

        assertion_failures = resolver_top_i.assertions_i.failure_count;
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
            tests_run, tests_failed, error_count, assertion_failures);
        if (error_count == 0 && assertion_failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: build.f
design/resolver_pkg.sv
design/read_trigger_gen.sv
design/ad2s1210_reader.sv
design/sample_router.sv
design/resolver_top.sv
verif/clock_gen.sv
verif/ad2s1210_model.sv
verif/resolver_assertions.sv
verif/resolver_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f build.f --top-module resolver_tb -o resolver_sim

./obj_dir/resolver_sim +verilator+error+limit+1000 | tee sim.log

grep -qx "Finished with no errors" sim.log
echo "Simulation passed"
